/* src/mdec_config.svh */
// Width and size definitions for the dequantization front end
// Coefficient, scale, quant, product and block geometry

`ifndef MDEC_CONFIG_SVH
`define MDEC_CONFIG_SVH

// ----------------------------------------------------------------------
// Stream field widths
// ----------------------------------------------------------------------
// Signed run-length coefficient
`define MDEC_COEF_W      10
// Unsigned per-coefficient scale
`define MDEC_SCALE_W     6
// Unsigned quant table entry
`define MDEC_QUANT_W     7
// Signed coef x scale, 10x6 fits in 16 bits
`define MDEC_SCALED_W    16
// Signed dequantized value after divide by 8
`define MDEC_OUT_W       20

// ----------------------------------------------------------------------
// Block geometry
// ----------------------------------------------------------------------
`define MDEC_IDX_W       6
`define MDEC_BLK_W       3
`define MDEC_BLOCK_SIZE  64

// Forced scales, DC uses 8 (x1.0 after /8), full block uses 16 (x2.0)
`define MDEC_DC_SCALE    8
`define MDEC_FULL_SCALE  16

`endif

/* src/mdecStreamPkg.sv */
// Coefficient stream words passed between the dequantization stages
// Input word, first-stage scaled word and dequantized output word
`include "mdec_config.svh"

package mdecStreamPkg;

	// ------------------------------------------------------------------
	// Input stream word, one per strobe from the run-length decoder
	// ------------------------------------------------------------------
	typedef struct packed {
		logic signed [`MDEC_COEF_W-1:0]  coef;
		logic [`MDEC_SCALE_W-1:0]        scale;
		// First coefficient of the block
		logic                            isDC;
		// Linear position inside the 8x8 block
		logic [`MDEC_IDX_W-1:0]          index;
		// Zigzag position, the quant tables are stored in zigzag order
		logic [`MDEC_IDX_W-1:0]          zagIndex;
		// Uncompressed matrix, quant table bypassed
		logic                            fullBlock;
		logic [`MDEC_BLK_W-1:0]          blockNum;
		// Last coefficient of the block
		logic                            matrixComplete;
	} coefIn_t;

	// ------------------------------------------------------------------
	// First-stage result, coef x scale with the sideband still needed
	// ------------------------------------------------------------------
	typedef struct packed {
		logic signed [`MDEC_SCALED_W-1:0] product;
		logic [`MDEC_IDX_W-1:0]           index;
		logic [`MDEC_BLK_W-1:0]           blockNum;
		logic                             fullBlock;
		logic                             matrixComplete;
	} scaledCoef_t;

	// ------------------------------------------------------------------
	// Dequantized word, ready for the IDCT coefficient store
	// ------------------------------------------------------------------
	typedef struct packed {
		logic signed [`MDEC_OUT_W-1:0]   value;
		logic [`MDEC_IDX_W-1:0]          index;
		logic [`MDEC_BLK_W-1:0]          blockNum;
		logic                            matrixComplete;
	} coefOut_t;

endpackage

/* src/mdecQuantPkg.sv */
// Quantization table types
// Table select enum and the table load word
`include "mdec_config.svh"

package mdecQuantPkg;

	// ------------------------------------------------------------------
	// Table select
	// ------------------------------------------------------------------
	// Luma blocks 0..1 read table 0, chroma blocks 2..7 read table 1
	typedef enum logic [0:0] {
		LUMA_TBL   = 1'b0,
		CHROMA_TBL = 1'b1
	} quantSel_t;

	// ------------------------------------------------------------------
	// Table write word
	// ------------------------------------------------------------------
	typedef struct packed {
		quantSel_t                   sel;
		// Zigzag order address
		logic [`MDEC_IDX_W-1:0]      addr;
		logic [`MDEC_QUANT_W-1:0]    value;
	} quantLoad_t;

endpackage

/* src/coefScaler.sv */
// First pipeline cycle: effective scale select, coef x scale product,
// quant table read request and registered sideband
`include "mdec_config.svh"

module coefScaler (
	input  logic                        i_clk,
	input  logic                        i_arstN,
	// Incoming coefficient stream
	input  logic                        i_valid,
	input  mdecStreamPkg::coefIn_t      i_coef,
	// Quant table read request, driven in the same cycle
	output logic [`MDEC_IDX_W-1:0]      o_quantRdIdx,
	output mdecQuantPkg::quantSel_t     o_quantSel,
	// Registered first-stage result
	output logic                        o_valid,
	output mdecStreamPkg::scaledCoef_t  o_scaled
);

	localparam logic [`MDEC_SCALE_W-1:0] DC_SCALE   = `MDEC_DC_SCALE;
	localparam logic [`MDEC_SCALE_W-1:0] FULL_SCALE = `MDEC_FULL_SCALE;

	logic [`MDEC_SCALE_W-1:0]                   effScale;
	// One extra bit for the zero-extended scale operand
	logic signed [`MDEC_COEF_W+`MDEC_SCALE_W:0] product;

	// ------------------------------------------------------------------
	// Scale selection
	// ------------------------------------------------------------------
	always_comb
	begin
		// Full block wins over DC, both bypass the stream scale
		if (i_coef.fullBlock)
			effScale = FULL_SCALE;
		else if (i_coef.isDC)
			effScale = DC_SCALE;
		else
			effScale = i_coef.scale;
	end

	// Scale is unsigned, so pad a zero before the signed multiply
	assign product = $signed(i_coef.coef) * $signed({1'b0, effScale});

	// ------------------------------------------------------------------
	// Quant table request
	// ------------------------------------------------------------------
	// Table is in zigzag order, no need to decode the linear index
	assign o_quantRdIdx = i_coef.zagIndex;
	// Any of the upper block bits set means a chroma block
	assign o_quantSel   = (i_coef.blockNum[`MDEC_BLK_W-1:1] != '0) ?
		mdecQuantPkg::CHROMA_TBL : mdecQuantPkg::LUMA_TBL;

	// ------------------------------------------------------------------
	// Stage register, lines up with the table read latency
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge i_clk)
	begin
		// Magnitude never exceeds 512 x 63, the top bit is pure sign
		o_scaled.product        <= product[`MDEC_SCALED_W-1:0];
		o_scaled.index          <= i_coef.index;
		o_scaled.blockNum       <= i_coef.blockNum;
		o_scaled.fullBlock      <= i_coef.fullBlock;
		o_scaled.matrixComplete <= i_coef.matrixComplete;
	end

	// Stream scale must be driven on every strobe, even if overridden
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		i_valid |-> !$isunknown(i_coef.scale));

endmodule

/* src/quantTable.sv */
// Two 64-entry quantization tables, luma and chroma
// Synchronous write port, registered-address read with new-data behaviour
`include "mdec_config.svh"

module quantTable (
	input  logic                        i_clk,
	// Table load port
	input  logic                        i_quantWrt,
	input  mdecQuantPkg::quantLoad_t    i_quantLoad,
	// Read port, address sampled at the clock edge
	input  logic [`MDEC_IDX_W-1:0]      i_rdIdx,
	input  mdecQuantPkg::quantSel_t     i_rdSel,
	output logic [`MDEC_QUANT_W-1:0]    o_quantValue
);

	// Table select on top of the zigzag index
	localparam int ADDR_W = `MDEC_IDX_W + 1;
	localparam int DEPTH  = 2 * `MDEC_BLOCK_SIZE;

	logic [`MDEC_QUANT_W-1:0] quantMem [DEPTH];
	logic [ADDR_W-1:0]        wrAddr;
	logic [ADDR_W-1:0]        rdAddr;

	assign wrAddr = {i_quantLoad.sel, i_quantLoad.addr};

	// ------------------------------------------------------------------
	// Write and read address register
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk)
	begin
		if (i_quantWrt)
		begin
			quantMem[wrAddr] <= i_quantLoad.value;
		end
		// Registered address keeps the output one cycle behind the request
		rdAddr <= {i_rdSel, i_rdIdx};
	end

	// Asynchronous read off the registered address
	// A write to the entry being read shows up right after the edge
	assign o_quantValue = quantMem[rdAddr];

	// Load word must be fully driven on every table write
	assert property (@(posedge i_clk)
		i_quantWrt |-> !$isunknown(i_quantLoad));

endmodule

/* src/coefCombiner.sv */
// Second pipeline cycle: multiply by quant or unity, divide by 8,
// registered dequantized word and output strobe
`include "mdec_config.svh"

module coefCombiner (
	input  logic                        i_clk,
	input  logic                        i_arstN,
	// First-stage result and its table entry, aligned
	input  logic                        i_valid,
	input  mdecStreamPkg::scaledCoef_t  i_scaled,
	input  logic [`MDEC_QUANT_W-1:0]    i_quantValue,
	// Dequantized output
	output logic                        o_valid,
	output mdecStreamPkg::coefOut_t     o_coef
);

	// Quant entry plus a zero sign bit
	logic signed [`MDEC_QUANT_W:0]                quantFactor;
	// 16 x 8 signed product
	logic signed [`MDEC_SCALED_W+`MDEC_QUANT_W:0] fullProduct;

	// ------------------------------------------------------------------
	// Quant multiply
	// ------------------------------------------------------------------
	// Uncompressed matrix ignores the table
	assign quantFactor = i_scaled.fullBlock ?
		(`MDEC_QUANT_W+1)'(1) : $signed({1'b0, i_quantValue});

	assign fullProduct = $signed(i_scaled.product) * quantFactor;

	// ------------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge i_clk)
	begin
		// Divide by 8, arithmetic, keep bits 22..3
		// Largest product is under 2^22 so bit 23 only repeats the sign
		o_coef.value          <= fullProduct[`MDEC_OUT_W+2:3];
		o_coef.index          <= i_scaled.index;
		o_coef.blockNum       <= i_scaled.blockNum;
		o_coef.matrixComplete <= i_scaled.matrixComplete;
	end

	// Standard mode needs a loaded table entry
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		i_valid && !i_scaled.fullBlock |-> !$isunknown(i_quantValue));

endmodule

/* src/coefBlockBuffer.sv */
// 64-entry coefficient store for the IDCT with written mask zero fill,
// block-ready pulse and registered read port
`include "mdec_config.svh"

module coefBlockBuffer (
	input  logic                             i_clk,
	input  logic                             i_arstN,
	// Dequantized stream
	input  logic                             i_wrt,
	input  mdecStreamPkg::coefOut_t          i_coef,
	// IDCT read side
	input  logic [`MDEC_IDX_W-1:0]           i_rdIdx,
	output logic signed [`MDEC_OUT_W-1:0]    o_rdData,
	// Block completion
	output logic                             o_blockReady,
	output logic [`MDEC_BLK_W-1:0]           o_readyBlockNum
);

	localparam int DEPTH = `MDEC_BLOCK_SIZE;

	logic signed [`MDEC_OUT_W-1:0] coefMem [DEPTH];
	logic [DEPTH-1:0]              writtenMask;
	logic [DEPTH-1:0]              wrBit;
	// Previous block closed, next write starts from an empty mask
	logic                          newBlock;

	assign wrBit = {{(DEPTH-1){1'b0}}, 1'b1} << i_coef.index;

	// ------------------------------------------------------------------
	// Coefficient storage
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk)
	begin
		if (i_wrt)
		begin
			coefMem[i_coef.index] <= i_coef.value;
		end
		// Sparse stream, unwritten positions read back as zero
		o_rdData <= writtenMask[i_rdIdx] ? coefMem[i_rdIdx] : '0;
	end

	// ------------------------------------------------------------------
	// Written mask and completion
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
		begin
			writtenMask     <= '0;
			newBlock        <= 1'b0;
			o_blockReady    <= 1'b0;
			o_readyBlockNum <= '0;
		end
		else
		begin
			o_blockReady <= i_wrt & i_coef.matrixComplete;
			if (i_wrt)
			begin
				// Old block stays readable until this first write
				if (newBlock)
					writtenMask <= wrBit;
				else
					writtenMask <= writtenMask | wrBit;
				newBlock <= i_coef.matrixComplete;
				if (i_coef.matrixComplete)
					o_readyBlockNum <= i_coef.blockNum;
			end
		end
	end

	// One completion word per block, never back to back
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_blockReady |=> !o_blockReady);

endmodule

/* src/dequantTop.sv */
// Dequantization front end top level
// Scaler and quant table in cycle one, combiner in cycle two, block buffer
`include "mdec_config.svh"

module dequantTop (
	input  logic                             i_clk,
	input  logic                             i_arstN,
	// Coefficient stream from the run-length decoder
	input  logic                             i_coefWrt,
	input  mdecStreamPkg::coefIn_t           i_coefIn,
	// Quant table load
	input  logic                             i_quantWrt,
	input  mdecQuantPkg::quantLoad_t         i_quantLoad,
	// Block buffer read
	input  logic [`MDEC_IDX_W-1:0]           i_rdIdx,
	// Dequantized stream, two cycles after the input strobe
	output logic                             o_coefWrt,
	output mdecStreamPkg::coefOut_t          o_coefOut,
	output logic signed [`MDEC_OUT_W-1:0]    o_rdData,
	output logic                             o_blockReady,
	output logic [`MDEC_BLK_W-1:0]           o_readyBlockNum
);

	logic [`MDEC_IDX_W-1:0]      quantRdIdx;
	mdecQuantPkg::quantSel_t     quantSel;
	logic [`MDEC_QUANT_W-1:0]    quantValue;
	logic                        scaledValid;
	mdecStreamPkg::scaledCoef_t  scaled;

	// ------------------------------------------------------------------
	// Cycle one, scale multiply and table lookup side by side
	// ------------------------------------------------------------------
	coefScaler uScaler (
		.i_clk        (i_clk),
		.i_arstN      (i_arstN),
		.i_valid      (i_coefWrt),
		.i_coef       (i_coefIn),
		.o_quantRdIdx (quantRdIdx),
		.o_quantSel   (quantSel),
		.o_valid      (scaledValid),
		.o_scaled     (scaled)
	);

	quantTable uQuantTable (
		.i_clk        (i_clk),
		.i_quantWrt   (i_quantWrt),
		.i_quantLoad  (i_quantLoad),
		.i_rdIdx      (quantRdIdx),
		.i_rdSel      (quantSel),
		.o_quantValue (quantValue)
	);

	// ------------------------------------------------------------------
	// Cycle two, quant multiply and divide by 8
	// ------------------------------------------------------------------
	coefCombiner uCombiner (
		.i_clk        (i_clk),
		.i_arstN      (i_arstN),
		.i_valid      (scaledValid),
		.i_scaled     (scaled),
		.i_quantValue (quantValue),
		.o_valid      (o_coefWrt),
		.o_coef       (o_coefOut)
	);

	// Store feeding the IDCT
	coefBlockBuffer uBlockBuffer (
		.i_clk           (i_clk),
		.i_arstN         (i_arstN),
		.i_wrt           (o_coefWrt),
		.i_coef          (o_coefOut),
		.i_rdIdx         (i_rdIdx),
		.o_rdData        (o_rdData),
		.o_blockReady    (o_blockReady),
		.o_readyBlockNum (o_readyBlockNum)
	);

endmodule

/* dv/tb_dequant.sv */
// Dequant front end testbench: table load, random sparse blocks, read sweeps
// Reference model, checking assertions, watchdog and summary
`include "mdec_config.svh"

module tb_dequant;

	localparam int SEED = 49262;
	localparam int NUM_BLOCKS = 12;
	// Reset plus one write per table entry
	localparam int LOAD_CYCLES = 2 * `MDEC_BLOCK_SIZE + 10;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 200 + LOAD_CYCLES;

	logic i_clk;
	logic i_arstN;
	logic i_coefWrt;
	mdecStreamPkg::coefIn_t i_coefIn;
	logic i_quantWrt;
	mdecQuantPkg::quantLoad_t i_quantLoad;
	logic [`MDEC_IDX_W-1:0] i_rdIdx;
	logic o_coefWrt;
	mdecStreamPkg::coefOut_t o_coefOut;
	logic signed [`MDEC_OUT_W-1:0] o_rdData;
	logic o_blockReady;
	logic [`MDEC_BLK_W-1:0] o_readyBlockNum;

	// Reference state, tables in zigzag order with the select bit on top
	logic [`MDEC_QUANT_W-1:0] qTbl [2*`MDEC_BLOCK_SIZE];
	logic signed [`MDEC_OUT_W-1:0] tbBuf [`MDEC_BLOCK_SIZE];
	logic [`MDEC_BLOCK_SIZE-1:0] tbMask;
	logic [`MDEC_QUANT_W-1:0] modelQuant;
	mdecStreamPkg::coefOut_t modelWord;
	logic signed [`MDEC_OUT_W-1:0] expRdData;
	logic sweeping;
	int errorCount = 0;
	int coefCount = 0;

	dequantTop uut (.*);

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------
	function automatic mdecStreamPkg::coefOut_t expectedWord(
		input mdecStreamPkg::coefIn_t c, input logic [`MDEC_QUANT_W-1:0] q);
		mdecStreamPkg::coefOut_t w;
		int mult;
		int prod;
		// Full block ignores the table, DC ignores the stream scale
		if (c.fullBlock)
			mult = `MDEC_FULL_SCALE;
		else if (c.isDC)
			mult = `MDEC_DC_SCALE * int'(q);
		else
			mult = int'(c.scale) * int'(q);
		prod = (int'($signed(c.coef)) * mult) >>> 3;
		w.value = prod[`MDEC_OUT_W-1:0];
		w.index = c.index;
		w.blockNum = c.blockNum;
		w.matrixComplete = c.matrixComplete;
		return w;
	endfunction

	// Blocks 0..1 read table 0, 2..7 table 1
	assign modelQuant = qTbl[{i_coefIn.blockNum >= 3'd2, i_coefIn.zagIndex}];
	assign modelWord = expectedWord(i_coefIn, modelQuant);
	assign expRdData = tbMask[i_rdIdx] ? tbBuf[i_rdIdx] : '0;

	task automatic logError(input string msg);
		errorCount++;
		$display("** Error @ %0t: %s", $time, msg);
	endtask

	// ------------------------------------------------------------------
	// Checking assertions
	// ------------------------------------------------------------------
	// Input is sampled at the edge after it is driven
	// Output word is sampled two edges after that
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_coefWrt == $past(i_coefWrt, 2))
		else logError("output strobe misplaced");
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_coefWrt |-> o_coefOut == $past(modelWord, 2))
		else logError($sformatf("wrong word %h", $sampled(o_coefOut)));
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_blockReady == $past(i_coefWrt && i_coefIn.matrixComplete, 3))
		else logError("block-ready pulse misplaced");
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_blockReady |-> o_readyBlockNum == $past(i_coefIn.blockNum, 3))
		else logError("wrong ready block number");
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		$past(sweeping) |-> o_rdData == $past(expRdData))
		else logError($sformatf("read data %h", $sampled(o_rdData)));
	assert property (@(posedge i_clk)
		(!i_arstN || $past(!i_arstN)) |-> !o_coefWrt && !o_blockReady)
		else logError("strobe high around reset");

	// ------------------------------------------------------------------
	// Stimulus tasks
	// ------------------------------------------------------------------
	task automatic loadTables();
		mdecQuantPkg::quantLoad_t ld;
		for (int a = 0; a < 2 * `MDEC_BLOCK_SIZE; a++)
		begin
			ld.sel = (a >= `MDEC_BLOCK_SIZE) ? mdecQuantPkg::CHROMA_TBL : mdecQuantPkg::LUMA_TBL;
			ld.addr = a[`MDEC_IDX_W-1:0];
			// Table 1 differs from table 0 in the top bit of every entry
			ld.value = ld.sel ? qTbl[a-`MDEC_BLOCK_SIZE] ^ 7'h40 : 7'($urandom);
			qTbl[a] = ld.value;
			@(posedge i_clk);
			i_quantWrt <= 1'b1;
			i_quantLoad <= ld;
		end
		@(posedge i_clk);
		i_quantWrt <= 1'b0;
	endtask

	task automatic sendBlock(input int blk, input logic full);
		mdecStreamPkg::coefIn_t c;
		mdecStreamPkg::coefOut_t w;
		int count;
		count = 1 + ($urandom % 16);
		tbMask = '0;
		c.scale = 6'($urandom);
		for (int k = 0; k < count; k++)
		begin
			c.coef = 10'($urandom);
			c.isDC = (k == 0);
			c.index = (k == 0) ? '0 : 6'($urandom);
			c.zagIndex = (k == 0) ? '0 : 6'($urandom);
			c.fullBlock = full;
			c.blockNum = 3'(blk);
			c.matrixComplete = (k == count - 1);
			w = expectedWord(c, qTbl[{blk >= 2, c.zagIndex}]);
			tbBuf[c.index] = w.value;
			tbMask[c.index] = 1'b1;
			coefCount++;
			@(posedge i_clk);
			i_coefWrt <= 1'b1;
			i_coefIn <= c;
			// Random gaps, otherwise back to back
			if ($urandom % 2)
			begin
				@(posedge i_clk);
				i_coefWrt <= 1'b0;
			end
		end
		@(posedge i_clk);
		i_coefWrt <= 1'b0;
	endtask

	task automatic sweepBuffer();
		int waitCycles;
		waitCycles = 0;
		while (!o_blockReady && waitCycles < 16)
		begin
			@(negedge i_clk);
			waitCycles++;
		end
		if (!o_blockReady)
		begin
			errorCount++;
			$display("No block-ready pulse seen after the block at %0t", $time);
		end
		for (int idx = 0; idx < `MDEC_BLOCK_SIZE; idx++)
		begin
			@(posedge i_clk);
			i_rdIdx <= 6'(idx);
			sweeping <= 1'b1;
		end
		@(posedge i_clk);
		sweeping <= 1'b0;
		repeat (2) @(posedge i_clk);
	endtask

	// ------------------------------------------------------------------
	// Clock, watchdog and main sequence
	// ------------------------------------------------------------------
	initial
	begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	initial
	begin
		#(TIMEOUT_CYCLES * 10);
		$display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		void'($urandom(SEED));
		i_arstN = 1'b0;
		i_coefWrt = 1'b0;
		i_coefIn = '0;
		i_quantWrt = 1'b0;
		i_quantLoad = '0;
		i_rdIdx = '0;
		sweeping = 1'b0;
		tbMask = '0;
		repeat (3) @(posedge i_clk);
		i_arstN <= 1'b1;
		loadTables();
		for (int b = 0; b < NUM_BLOCKS; b++)
		begin
			// First blocks pin one luma, one chroma and one full block
			sendBlock((b < 2) ? b * 3 : $urandom % 8,
				(b == 2) || ((b > 2) && ($urandom % 4 == 0)));
			sweepBuffer();
		end
		$display("Summary: %0d errors in %0d blocks, %0d coefficients", errorCount,
			NUM_BLOCKS, coefCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+src
src/mdecStreamPkg.sv
src/mdecQuantPkg.sv
src/coefScaler.sv
src/quantTable.sv
src/coefCombiner.sv
src/coefBlockBuffer.sv
src/dequantTop.sv
dv/tb_dequant.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dequant testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f filelist.f --top-module tb_dequant -Mdir obj_dir \
	&& ./obj_dir/Vtb_dequant > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
